// File: rtl/amber_soc_pkg.sv
package amber_soc_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    // Top nibble of the address picks the slave, 3 to 15 unmapped
    localparam int SLAVE_SEL_MSB = 31;
    localparam int SLAVE_SEL_LSB = 28;
    localparam int SLAVE_SEL_W   = SLAVE_SEL_MSB - SLAVE_SEL_LSB + 1;
    localparam int N_SLAVES      = 3;

    typedef enum logic [1:0] {
        SLV_BOOT_MEM = 2'd0,
        SLV_TIMER    = 2'd1,
        SLV_IC       = 2'd2
    } slave_e;

    // Boot memory word index from adr[9:2]
    localparam int BOOT_MEM_WORDS = 256;
    localparam int BOOT_IDX_W     = $clog2(BOOT_MEM_WORDS);

    // Timer index from adr[5:4], register from adr[3:2]
    localparam int         N_TIMERS  = 3;
    localparam logic [1:0] TMR_LOAD  = 2'd0;
    localparam logic [1:0] TMR_VALUE = 2'd1;
    localparam logic [1:0] TMR_CTRL  = 2'd2;
    localparam logic [1:0] TMR_CLEAR = 2'd3;

    // Interrupt sources: timers in 2:0, external lines in 4:3
    localparam int         N_IRQ_SRC      = 5;
    localparam logic [2:0] IC_IRQ_STATUS  = 3'd0;
    localparam logic [2:0] IC_FIRQ_STATUS = 3'd1;
    localparam logic [2:0] IC_RAW_STATUS  = 3'd2;
    localparam logic [2:0] IC_IRQ_EN_SET  = 3'd3;
    localparam logic [2:0] IC_IRQ_EN_CLR  = 3'd4;
    localparam logic [2:0] IC_FIRQ_EN_SET = 3'd5;
    localparam logic [2:0] IC_FIRQ_EN_CLR = 3'd6;

endpackage

// File: rtl/wb_slave_if.sv
`timescale 1ns/1ps

interface wb_slave_if
    import amber_soc_pkg::*;
();

    // Request side, driven by the decoder
    logic [WB_ADR_W-1:0] adr;
    logic [WB_SEL_W-1:0] sel;
    logic                we;
    logic [WB_DAT_W-1:0] dat_w;
    logic                stb;

    // Response side, driven by the slave
    logic [WB_DAT_W-1:0] dat_r;
    logic                ack;
    logic                err;

    modport decode (
        output adr, sel, we, dat_w, stb
    );

    modport slave (
        input  adr, sel, we, dat_w, stb,
        output dat_r, ack, err
    );

    // Response mux only looks at the return path
    modport result (
        input dat_r, ack, err
    );

endinterface

// File: rtl/wb_slave_decode.sv
`timescale 1ns/1ps

module wb_slave_decode
    import amber_soc_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic [WB_ADR_W-1:0] i_wb_adr,
    input  logic [WB_SEL_W-1:0] i_wb_sel,
    input  logic                i_wb_we,
    input  logic [WB_DAT_W-1:0] i_wb_dat,
    input  logic                i_wb_stb,
    input  logic                i_wb_cyc,
    wb_slave_if.decode          o_slv [N_SLAVES],
    output slave_e              o_slave_sel,
    output logic                o_dec_err
);

    logic [SLAVE_SEL_W-1:0] field;
    logic                   mapped;
    logic                   req;
    logic                   err_q;

    assign field  = i_wb_adr[SLAVE_SEL_MSB:SLAVE_SEL_LSB];
    assign mapped = 32'(field) < N_SLAVES;
    // Strobe only counts inside a bus cycle
    assign req    = i_wb_stb & i_wb_cyc;

    // --------------------------------------------------
    // Fan out the request to every slave bus
    // --------------------------------------------------
    for (genvar s = 0; s < N_SLAVES; s++) begin : g_slv
        assign o_slv[s].adr   = i_wb_adr;
        assign o_slv[s].sel   = i_wb_sel;
        assign o_slv[s].we    = i_wb_we;
        assign o_slv[s].dat_w = i_wb_dat;
        // Only the addressed slave sees a strobe
        assign o_slv[s].stb   = req & mapped & (field == SLAVE_SEL_W'(s));
    end

    // Unmapped fields fall back to slave 0, whose ack stays low anyway
    assign o_slave_sel = mapped ? slave_e'(field[1:0]) : SLV_BOOT_MEM;

    // --------------------------------------------------
    // Error pulse for unmapped accesses
    // --------------------------------------------------
    // One cycle high, then low while stb is still held
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & ~mapped & ~err_q;
        end
    end

    assign o_dec_err = err_q;

endmodule

// File: rtl/boot_mem.sv
`timescale 1ns/1ps

module boot_mem
    import amber_soc_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    wb_slave_if.slave i_bus
);

    logic [WB_DAT_W-1:0]   mem [BOOT_MEM_WORDS];
    logic [BOOT_IDX_W-1:0] idx;
    logic [WB_DAT_W-1:0]   rd_q;
    logic                  ack_q;
    logic                  start;

    // Word index, byte offset bits ignored
    assign idx   = i_bus.adr[BOOT_IDX_W+1:2];
    // New access only when the previous ack has gone
    assign start = i_bus.stb & ~ack_q;

    // Byte lane writes
    always_ff @(posedge i_clk) begin
        if (start && i_bus.we) begin
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (i_bus.sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_bus.dat_w[b*8 +: 8];
                end
            end
        end
    end

    // Full word read, lands together with ack
    always_ff @(posedge i_clk) begin
        if (start) begin
            rd_q <= mem[idx];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;
        end
    end

    assign i_bus.dat_r = rd_q;
    assign i_bus.ack   = ack_q;
    assign i_bus.err   = 1'b0;

endmodule

// File: rtl/timer_module.sv
`timescale 1ns/1ps

module timer_module
    import amber_soc_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    wb_slave_if.slave           i_bus,
    output logic [N_TIMERS-1:0] o_timer_int
);

    logic [WB_DAT_W-1:0] load_q  [N_TIMERS];
    logic [WB_DAT_W-1:0] count_q [N_TIMERS];
    logic [N_TIMERS-1:0] en_q;
    logic [N_TIMERS-1:0] flag_q;
    logic [1:0]          tidx;
    logic [1:0]          off;
    logic                valid;
    logic                start;
    logic                wr;
    logic                ack_q;
    logic                err_q;
    logic [WB_DAT_W-1:0] rd_d;
    logic [WB_DAT_W-1:0] rd_q;

    assign tidx  = i_bus.adr[5:4];
    assign off   = i_bus.adr[3:2];
    // Timer slot 3 does not exist and answers with err
    assign valid = 32'(tidx) < N_TIMERS;
    assign start = i_bus.stb & ~ack_q & ~err_q;
    assign wr    = start & i_bus.we & valid;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= start & valid;
            err_q <= start & ~valid;
        end
    end

    // --------------------------------------------------
    // Down counters
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int t = 0; t < N_TIMERS; t++) begin
                load_q[t]  <= '0;
                count_q[t] <= '0;
            end
            en_q   <= '0;
            flag_q <= '0;
        end else begin
            for (int t = 0; t < N_TIMERS; t++) begin
                // Flag at zero, then reload and keep going
                if (en_q[t]) begin
                    if (count_q[t] == '0) begin
                        flag_q[t]  <= 1'b1;
                        count_q[t] <= load_q[t];
                    end else begin
                        count_q[t] <= count_q[t] - 1'b1;
                    end
                end
                // Bus writes take priority over counting
                if (wr && tidx == 2'(t)) begin
                    case (off)
                        TMR_LOAD: begin
                            load_q[t]  <= i_bus.dat_w;
                            count_q[t] <= i_bus.dat_w;
                        end
                        TMR_CTRL:  en_q[t]   <= i_bus.dat_w[0];
                        TMR_CLEAR: flag_q[t] <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // --------------------------------------------------
    // Read back
    // --------------------------------------------------
    always_comb begin
        rd_d = '0;
        for (int t = 0; t < N_TIMERS; t++) begin
            if (tidx == 2'(t)) begin
                case (off)
                    TMR_LOAD:  rd_d = load_q[t];
                    TMR_VALUE: rd_d = count_q[t];
                    TMR_CTRL:  rd_d = WB_DAT_W'(en_q[t]);
                    // Clear slot reads back the pending flag
                    default:   rd_d = WB_DAT_W'(flag_q[t]);
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            rd_q <= rd_d;
        end
    end

    assign i_bus.dat_r = rd_q;
    assign i_bus.ack   = ack_q;
    assign i_bus.err   = err_q;
    assign o_timer_int = flag_q;

endmodule

// File: rtl/interrupt_controller.sv
`timescale 1ns/1ps

module interrupt_controller
    import amber_soc_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    wb_slave_if.slave           i_bus,
    input  logic [N_TIMERS-1:0] i_timer_int,
    input  logic [1:0]          i_ext_int,
    output logic                o_irq,
    output logic                o_firq
);

    logic [N_IRQ_SRC-1:0] raw;
    logic [N_IRQ_SRC-1:0] irq_en_q;
    logic [N_IRQ_SRC-1:0] firq_en_q;
    logic [N_IRQ_SRC-1:0] irq_stat;
    logic [N_IRQ_SRC-1:0] firq_stat;
    logic [N_IRQ_SRC-1:0] wr_bits;
    logic [2:0]           off;
    logic                 valid;
    logic                 start;
    logic                 wr;
    logic                 ack_q;
    logic                 err_q;
    logic                 irq_q;
    logic                 firq_q;
    logic [WB_DAT_W-1:0]  rd_d;
    logic [WB_DAT_W-1:0]  rd_q;

    // Timers low, external lines high
    assign raw       = {i_ext_int, i_timer_int};
    assign irq_stat  = raw & irq_en_q;
    assign firq_stat = raw & firq_en_q;

    assign off     = i_bus.adr[4:2];
    // Offset 7 is unused and answers with err
    assign valid   = off <= IC_FIRQ_EN_CLR;
    assign start   = i_bus.stb & ~ack_q & ~err_q;
    assign wr      = start & i_bus.we & valid;
    assign wr_bits = i_bus.dat_w[N_IRQ_SRC-1:0];

    // --------------------------------------------------
    // Handshake and enable masks
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            irq_en_q  <= '0;
            firq_en_q <= '0;
        end else begin
            ack_q <= start & valid;
            err_q <= start & ~valid;
            // Set and clear act only on the ones written
            if (wr) begin
                case (off)
                    IC_IRQ_EN_SET:  irq_en_q  <= irq_en_q | wr_bits;
                    IC_IRQ_EN_CLR:  irq_en_q  <= irq_en_q & ~wr_bits;
                    IC_FIRQ_EN_SET: firq_en_q <= firq_en_q | wr_bits;
                    IC_FIRQ_EN_CLR: firq_en_q <= firq_en_q & ~wr_bits;
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Read back
    // --------------------------------------------------
    always_comb begin
        case (off)
            IC_IRQ_STATUS:  rd_d = WB_DAT_W'(irq_stat);
            IC_FIRQ_STATUS: rd_d = WB_DAT_W'(firq_stat);
            IC_RAW_STATUS:  rd_d = WB_DAT_W'(raw);
            IC_IRQ_EN_SET,
            IC_IRQ_EN_CLR:  rd_d = WB_DAT_W'(irq_en_q);
            IC_FIRQ_EN_SET,
            IC_FIRQ_EN_CLR: rd_d = WB_DAT_W'(firq_en_q);
            default:        rd_d = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            rd_q <= rd_d;
        end
    end

    // Outputs to the core, one cycle behind the masked status
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            irq_q  <= 1'b0;
            firq_q <= 1'b0;
        end else begin
            irq_q  <= |irq_stat;
            firq_q <= |firq_stat;
        end
    end

    assign i_bus.dat_r = rd_q;
    assign i_bus.ack   = ack_q;
    assign i_bus.err   = err_q;
    assign o_irq       = irq_q;
    assign o_firq      = firq_q;

endmodule

// File: rtl/wb_response_mux.sv
`timescale 1ns/1ps

module wb_response_mux
    import amber_soc_pkg::*;
(
    wb_slave_if.result          i_slv [N_SLAVES],
    input  slave_e              i_slave_sel,
    input  logic                i_dec_err,
    output logic [WB_DAT_W-1:0] o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_wb_err
);

    logic [WB_DAT_W-1:0] dat [N_SLAVES];
    logic [N_SLAVES-1:0] ack;
    logic [N_SLAVES-1:0] err;

    // Flatten the interface array for indexing
    for (genvar s = 0; s < N_SLAVES; s++) begin : g_collect
        assign dat[s] = i_slv[s].dat_r;
        assign ack[s] = i_slv[s].ack;
        assign err[s] = i_slv[s].err;
    end

    // Decoder error is merged with the selected slave's err
    always_comb begin
        o_wb_dat = '0;
        o_wb_ack = 1'b0;
        o_wb_err = i_dec_err;
        for (int s = 0; s < N_SLAVES; s++) begin
            if (i_slave_sel == slave_e'(s)) begin
                o_wb_dat = dat[s];
                o_wb_ack = ack[s];
                o_wb_err = i_dec_err | err[s];
            end
        end
    end

endmodule

// File: rtl/amber_soc.sv
`timescale 1ns/1ps

module amber_soc
    import amber_soc_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    // Master bus
    input  logic [WB_ADR_W-1:0] i_wb_adr,
    input  logic [WB_SEL_W-1:0] i_wb_sel,
    input  logic                i_wb_we,
    input  logic [WB_DAT_W-1:0] i_wb_dat,
    input  logic                i_wb_stb,
    input  logic                i_wb_cyc,
    output logic [WB_DAT_W-1:0] o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_wb_err,
    // Interrupts
    input  logic [1:0]          i_ext_int,
    output logic                o_irq,
    output logic                o_firq
);

    slave_e              slave_sel;
    logic                dec_err;
    logic [N_TIMERS-1:0] timer_int;

    // One bus per slave, indexed by slave_e
    wb_slave_if u_slv_if [N_SLAVES] ();

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    wb_slave_decode u_wb_slave_decode (
        .i_clk       ( i_clk     ),
        .i_arst_n    ( i_arst_n  ),
        .i_wb_adr    ( i_wb_adr  ),
        .i_wb_sel    ( i_wb_sel  ),
        .i_wb_we     ( i_wb_we   ),
        .i_wb_dat    ( i_wb_dat  ),
        .i_wb_stb    ( i_wb_stb  ),
        .i_wb_cyc    ( i_wb_cyc  ),
        .o_slv       ( u_slv_if  ),
        .o_slave_sel ( slave_sel ),
        .o_dec_err   ( dec_err   )
    );

    // --------------------------------------------------
    // Slaves
    // --------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk    ( i_clk                    ),
        .i_arst_n ( i_arst_n                 ),
        .i_bus    ( u_slv_if[SLV_BOOT_MEM]   )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk               ),
        .i_arst_n    ( i_arst_n            ),
        .i_bus       ( u_slv_if[SLV_TIMER] ),
        .o_timer_int ( timer_int           )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       ( i_clk            ),
        .i_arst_n    ( i_arst_n         ),
        .i_bus       ( u_slv_if[SLV_IC] ),
        .i_timer_int ( timer_int        ),
        .i_ext_int   ( i_ext_int        ),
        .o_irq       ( o_irq            ),
        .o_firq      ( o_firq           )
    );

    // --------------------------------------------------
    // Return path to the master
    // --------------------------------------------------
    wb_response_mux u_wb_response_mux (
        .i_slv       ( u_slv_if  ),
        .i_slave_sel ( slave_sel ),
        .i_dec_err   ( dec_err   ),
        .o_wb_dat    ( o_wb_dat  ),
        .o_wb_ack    ( o_wb_ack  ),
        .o_wb_err    ( o_wb_err  )
    );

endmodule

// File: testbench/amber_soc_sva.sv
`timescale 1ns/1ps

module amber_soc_sva
    import amber_soc_pkg::*;
(
    input logic                i_clk,
    input logic                i_arst_n,
    input logic [WB_ADR_W-1:0] i_wb_adr,
    input logic                i_wb_we,
    input logic                i_wb_stb,
    input logic                i_wb_cyc,
    input logic                i_wb_ack,
    input logic                i_wb_err,
    input logic                i_irq,
    input logic                i_firq
);

    // Number of failed assertions
    int   n_fail = 0;
    logic resp;
    logic ic_written;

    assign resp = i_wb_ack | i_wb_err;

    // Set by the first write request sampled for the interrupt controller
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ic_written <= 1'b0;
        end else if (i_wb_stb && i_wb_cyc && i_wb_we &&
                     i_wb_adr[SLAVE_SEL_MSB:SLAVE_SEL_LSB] == SLAVE_SEL_W'(SLV_IC)) begin
            ic_written <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Bus handshake
    // --------------------------------------------------
    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_wb_ack && i_wb_err))
        else begin n_fail++; $error("ack and err high in the same cycle"); end

    a_resp_one_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        resp |=> !resp)
        else begin n_fail++; $error("ack or err held longer than one cycle"); end

    // Response only to a strobe seen on the previous edge
    a_resp_after_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        resp |-> $past(i_wb_stb && i_wb_cyc))
        else begin n_fail++; $error("ack or err without a preceding strobe"); end

    // --------------------------------------------------
    // Interrupts
    // --------------------------------------------------
    // Masks are zero out of reset so no interrupt before any IC write
    a_irq_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !ic_written |-> !(i_irq || i_firq))
        else begin n_fail++; $error("interrupt output high with both masks zero"); end

endmodule

bind amber_soc amber_soc_sva u_amber_soc_sva (
    .i_clk    ( i_clk    ),
    .i_arst_n ( i_arst_n ),
    .i_wb_adr ( i_wb_adr ),
    .i_wb_we  ( i_wb_we  ),
    .i_wb_stb ( i_wb_stb ),
    .i_wb_cyc ( i_wb_cyc ),
    .i_wb_ack ( o_wb_ack ),
    .i_wb_err ( o_wb_err ),
    .i_irq    ( o_irq    ),
    .i_firq   ( o_firq   )
);

// File: testbench/tb_amber_soc.sv
`timescale 1ns/1ps

module tb_amber_soc
    import amber_soc_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    // About 2000 cycles of tests, watchdog gives a wide margin
    localparam int TEST_CYCLES = 2000;
    localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 5 / 2;
    localparam int ACK_LIMIT   = 8;
    localparam int N_MEM_CHECK = 16;
    localparam int N_PARTIAL   = 32;

    logic                clk;
    logic                arst_n;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_SEL_W-1:0] wb_sel;
    logic                wb_we;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic                wb_stb;
    logic                wb_cyc;
    logic [1:0]          ext_int;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;
    logic                wb_err;
    logic                irq;
    logic                firq;

    int                  n_mismatch;
    int                  n_other;
    int                  n_assert;
    int                  cycle = 0;
    // Cycle in which the last access saw ack or err
    int                  ack_cycle;
    // Reference model of the boot memory
    logic [WB_DAT_W-1:0] ref_mem [BOOT_MEM_WORDS];

    amber_soc u_amber_soc (
        .i_clk     ( clk      ),
        .i_arst_n  ( arst_n   ),
        .i_wb_adr  ( wb_adr   ),
        .i_wb_sel  ( wb_sel   ),
        .i_wb_we   ( wb_we    ),
        .i_wb_dat  ( wb_dat_w ),
        .i_wb_stb  ( wb_stb   ),
        .i_wb_cyc  ( wb_cyc   ),
        .o_wb_dat  ( wb_dat_r ),
        .o_wb_ack  ( wb_ack   ),
        .o_wb_err  ( wb_err   ),
        .i_ext_int ( ext_int  ),
        .o_irq     ( irq      ),
        .o_firq    ( firq     )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Address helpers
    // --------------------------------------------------
    function automatic logic [WB_ADR_W-1:0] slave_adr(input slave_e s, input logic [27:0] off);
        return {SLAVE_SEL_W'(s), off};
    endfunction

    function automatic logic [WB_ADR_W-1:0] timer_adr(input int t, input logic [1:0] reg_off);
        return slave_adr(SLV_TIMER, {22'h0, 2'(t), reg_off, 2'b00});
    endfunction

    function automatic logic [WB_ADR_W-1:0] ic_adr(input logic [2:0] reg_off);
        return slave_adr(SLV_IC, {23'h0, reg_off, 2'b00});
    endfunction

    // --------------------------------------------------
    // Checks and bus tasks
    // --------------------------------------------------
    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            n_mismatch++;
            $display("mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic run_access(
        input  logic [WB_ADR_W-1:0] adr,
        input  logic [WB_SEL_W-1:0] sel,
        input  logic                we,
        input  logic [WB_DAT_W-1:0] dat,
        output logic [WB_DAT_W-1:0] rdata,
        output logic                got_ack,
        output logic                got_err
    );
        int waited;
        waited   = 0;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_we    = we;
        wb_dat_w = dat;
        wb_stb   = 1'b1;
        wb_cyc   = 1'b1;
        while (!got_ack && !got_err && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
            got_ack = wb_ack;
            got_err = wb_err;
        end
        rdata     = wb_dat_r;
        ack_cycle = cycle;
        wb_stb    = 1'b0;
        wb_cyc    = 1'b0;
        wb_we     = 1'b0;
        if (!got_ack && !got_err) begin
            n_other++;
            $display("no ack or err within %0d cycles for address 0x%08h", ACK_LIMIT, adr);
        end
        // One idle cycle between accesses
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input logic [WB_ADR_W-1:0] adr, input logic [WB_SEL_W-1:0] sel,
                              input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused_rd;
        logic                got_ack;
        logic                got_err;
        run_access(adr, sel, 1'b1, dat, unused_rd, got_ack, got_err);
        check_eq("o_wb_ack", 32'(got_ack), 32'h1);
    endtask

    task automatic read_word(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
        logic got_ack;
        logic got_err;
        run_access(adr, 4'hF, 1'b0, '0, data, got_ack, got_err);
        check_eq("o_wb_ack", 32'(got_ack), 32'h1);
    endtask

    // Waits for o_irq or o_firq to reach a level, limit counted from the last ack
    task automatic wait_irq_level(input logic fast, input logic level, input int limit);
        logic cur;
        cur = fast ? firq : irq;
        while (cur !== level && (cycle - ack_cycle) <= limit) begin
            @(posedge clk);
            #1;
            cur = fast ? firq : irq;
        end
        if (fast) begin
            check_eq("o_firq", 32'(cur), 32'(level));
        end else begin
            check_eq("o_irq", 32'(cur), 32'(level));
        end
        assert ((cycle - ack_cycle) <= limit) else begin
            n_other++;
            $display("interrupt output took more than %0d cycles to change", limit);
        end
    endtask

    // Enable, check and disable one external line on the irq or firq path
    task automatic check_irq_path(input logic fast);
        int                  src;
        logic [WB_DAT_W-1:0] mask;
        logic [WB_DAT_W-1:0] rd;
        src  = fast ? 4 : 3;
        mask = 32'h1 << src;
        ext_int[src-3] = 1'b1;
        write_word(ic_adr(fast ? IC_FIRQ_EN_SET : IC_IRQ_EN_SET), 4'hF, mask);
        wait_irq_level(fast, 1'b1, 2);
        // The other output has a zero mask
        check_eq(fast ? "o_irq" : "o_firq", 32'(fast ? irq : firq), 32'h0);
        read_word(ic_adr(fast ? IC_FIRQ_STATUS : IC_IRQ_STATUS), rd);
        check_eq("o_wb_dat (masked status)", rd, mask);
        write_word(ic_adr(fast ? IC_FIRQ_EN_CLR : IC_IRQ_EN_CLR), 4'hF, mask);
        wait_irq_level(fast, 1'b0, 2);
        check_eq(fast ? "o_irq" : "o_firq", 32'(fast ? irq : firq), 32'h0);
        ext_int[src-3] = 1'b0;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int                  idx_list [N_MEM_CHECK];
        int                  idx;
        int                  l;
        int                  start;
        logic [WB_DAT_W-1:0] rd;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
        logic [3:0]          field;
        logic                got_ack;
        logic                got_err;

        clk        = 1'b0;
        arst_n     = 1'b0;
        wb_adr     = '0;
        wb_sel     = '0;
        wb_we      = 1'b0;
        wb_dat_w   = '0;
        wb_stb     = 1'b0;
        wb_cyc     = 1'b0;
        ext_int    = '0;
        n_mismatch = 0;
        n_other    = 0;
        void'($urandom(82995));
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        // Boot memory, full words first so every checked byte is known
        for (int i = 0; i < N_MEM_CHECK; i++) begin
            idx_list[i] = i * 16 + int'($urandom % 16);
            dat = $urandom;
            write_word(slave_adr(SLV_BOOT_MEM, 28'({idx_list[i], 2'b00})), 4'hF, dat);
            ref_mem[idx_list[i]] = dat;
        end
        for (int i = 0; i < N_PARTIAL; i++) begin
            idx = idx_list[$urandom % N_MEM_CHECK];
            dat = $urandom;
            sel = 4'($urandom);
            write_word(slave_adr(SLV_BOOT_MEM, 28'({idx, 2'b00})), sel, dat);
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (sel[b]) begin
                    ref_mem[idx][b*8 +: 8] = dat[b*8 +: 8];
                end
            end
        end
        for (int i = 0; i < N_MEM_CHECK; i++) begin
            read_word(slave_adr(SLV_BOOT_MEM, 28'({idx_list[i], 2'b00})), rd);
            check_eq("o_wb_dat (boot memory)", rd, ref_mem[idx_list[i]]);
        end

        // Unmapped top fields, both ends of the range and random ones
        for (int i = 0; i < 6; i++) begin
            field = (i == 0) ? 4'd3 : (i == 1) ? 4'd15 : 4'(3 + $urandom % 13);
            run_access({field, 28'($urandom)}, 4'hF, 1'(i % 2), $urandom, rd, got_ack, got_err);
            check_eq("o_wb_err", 32'(got_err), 32'h1);
            check_eq("o_wb_ack", 32'(got_ack), 32'h0);
        end

        // Timers, one at a time
        for (int t = 0; t < N_TIMERS; t++) begin
            l = 4 + int'($urandom % 37);
            write_word(timer_adr(t, TMR_LOAD), 4'hF, 32'(l));
            write_word(timer_adr(t, TMR_CTRL), 4'hF, 32'h1);
            start = ack_cycle;
            rd    = '0;
            while (!rd[t] && (ack_cycle - start) <= l + 10) begin
                read_word(timer_adr(t, TMR_VALUE), dat);
                assert (dat <= 32'(l)) else begin
                    n_mismatch++;
                    $display("mismatch TMR_VALUE: got 0x%08h above load 0x%08h", dat, l);
                end
                read_word(ic_adr(IC_RAW_STATUS), rd);
            end
            check_eq("o_wb_dat (raw status timer bit)", 32'(rd[t]), 32'h1);
            assert ((ack_cycle - start) <= l + 10) else begin
                n_other++;
                $display("timer %0d flag not seen within %0d cycles", t, l + 10);
            end
            // Stop the timer before clearing so the flag cannot come back
            write_word(timer_adr(t, TMR_CTRL), 4'hF, 32'h0);
            write_word(timer_adr(t, TMR_CLEAR), 4'hF, 32'h0);
            start = ack_cycle;
            read_word(ic_adr(IC_RAW_STATUS), rd);
            check_eq("o_wb_dat (raw status timer bit)", 32'(rd[t]), 32'h0);
            assert ((ack_cycle - start) < l) else begin
                n_other++;
                $display("timer %0d clear check came too late", t);
            end
        end

        // Nothing enabled yet
        check_eq("o_irq", 32'(irq), 32'h0);
        check_eq("o_firq", 32'(firq), 32'h0);
        check_irq_path(1'b0);
        check_irq_path(1'b1);

        n_assert = u_amber_soc.u_amber_soc_sva.n_fail;
        $display("errors: mismatch %0d, other %0d, assertion %0d", n_mismatch, n_other, n_assert);
        if (n_mismatch + n_other + n_assert == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("errors: mismatch %0d, other %0d, watchdog expired after %0d ns",
                 n_mismatch, n_other, WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: amber_soc.f
rtl/amber_soc_pkg.sv
rtl/wb_slave_if.sv
rtl/wb_slave_decode.sv
rtl/boot_mem.sv
rtl/timer_module.sv
rtl/interrupt_controller.sv
rtl/wb_response_mux.sv
rtl/amber_soc.sv
testbench/amber_soc_sva.sv
testbench/tb_amber_soc.sv

// File: build.sh
#!/bin/sh
# Compile the amber_soc testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_amber_soc -f amber_soc.f -o Vtb_amber_soc
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

# Keep running after an assertion error so the closing line is printed
./obj_dir/Vtb_amber_soc +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
